// File: rtl/qr_pkg.sv
package qr_pkg;

	// Matrix data format, signed Q2.10
	localparam int DATA_W    = 13;
	localparam int DATA_FRAC = 10;

	// Inverse CORDIC gain, about 0.60725 in Q0.10
	localparam int K_W    = 11;
	localparam int K_FRAC = 10;
	localparam logic signed [K_W-1:0] K_GAIN = 11'sd622;

	// Matrix shape and addressing
	localparam int ROW_NUM = 4;
	localparam int COL_NUM = 2;
	localparam int ROW_W   = 2;
	localparam int COL_W   = 1;

	// Rotation schedule
	localparam int ITER_NUM       = 12;
	localparam int ITER_PER_CYCLE = 4;
	localparam int ITER_W         = 4;

	// Output side, r11, r12 and r22
	localparam int R_NUM    = 3;
	localparam int WR_IDX_W = 2;

	typedef enum logic [3:0] {
		IDLE, READ0, READ1, LOAD_A, ROT_A, SCALE_A,
		LOAD_B, ROT_B, SCALE_B, WRITE, DONE
	} qr_state_t;

	typedef enum logic [2:0] {
		CELL_HOLD, CELL_CLEAR, CELL_LOAD, CELL_ROT, CELL_SCALE
	} cell_op_t;

	// Multiply by K and drop the gain fraction, truncating toward minus infinity
	function automatic logic signed [DATA_W-1:0] k_scale(input logic signed [DATA_W-1:0] v);
		logic signed [DATA_W+K_W-1:0] p;
		p = v * K_GAIN;
		return p[K_FRAC +: DATA_W];
	endfunction

endpackage

// File: rtl/qr_step_counter.sv
`timescale 1ns/10ps

module qr_step_counter import qr_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  logic                  iter_step,
	input  logic                  row_step,
	input  logic                  wr_step,
	output logic [ITER_W-1:0]     iter,
	output logic                  iter_last,
	output logic [ROW_W-1:0]      row,
	output logic                  row_last,
	output logic [WR_IDX_W-1:0]   wr_idx
);

	assign iter_last = iter == ITER_W'(ITER_NUM - ITER_PER_CYCLE);
	assign row_last  = row == '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			iter   <= '0;
			row    <= ROW_W'(ROW_NUM - 1);
			wr_idx <= '0;
		end else if (start) begin
			iter   <= '0;
			row    <= ROW_W'(ROW_NUM - 1);
			wr_idx <= '0;
		end else begin
			// Four micro-rotations per step and back to zero once the phase ends
			if (iter_step) begin
				iter <= iter_last ? '0 : iter + ITER_W'(ITER_PER_CYCLE);
			end
			// Bottom row first; after row 0 this wraps back to the top row
			if (row_step) begin
				row <= row - 1'b1;
			end
			if (wr_step) begin
				wr_idx <= wr_idx + 1'b1;
			end
		end
	end

	// The FSM never steps past the last index of a phase
	assert property (@(posedge clk) disable iff (rst)
		(iter_step && iter_last) |=> !iter_step);

	// Index only leaves zero while the FSM is stepping a rotation phase
	assert property (@(posedge clk) disable iff (rst) (iter != '0) |-> iter_step);

endmodule

// File: rtl/cordic_vector_cell.sv
`timescale 1ns/10ps

module cordic_vector_cell import qr_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  cell_op_t                     op,
	input  logic [ITER_W-1:0]            iter,
	input  logic signed [DATA_W-1:0]     load_y,
	output logic signed [DATA_W-1:0]     x,
	output logic signed [DATA_W-1:0]     y,
	output logic [ITER_PER_CYCLE-1:0]    dir,
	output logic                         neg
);

	logic signed [DATA_W-1:0] cx;
	logic signed [DATA_W-1:0] cy;
	logic signed [DATA_W-1:0] tx;
	logic signed [DATA_W-1:0] rot_x;
	logic signed [DATA_W-1:0] rot_y;
	logic [ITER_W-1:0]        sh;

	// Four chained micro-rotations, each steering y toward zero
	always_comb begin
		// Left half-plane vector is first flipped by 180 degrees
		neg = (op == CELL_ROT) && (iter == '0) && x[DATA_W-1];
		cx  = neg ? -x : x;
		cy  = neg ? -y : y;
		for (int k = 0; k < ITER_PER_CYCLE; k++) begin
			sh     = iter + ITER_W'(k);
			dir[k] = ~cy[DATA_W-1];
			tx     = cx;
			if (dir[k]) begin
				cx = cx + (cy >>> sh);
				cy = cy - (tx >>> sh);
			end else begin
				cx = cx - (cy >>> sh);
				cy = cy + (tx >>> sh);
			end
		end
		rot_x = cx;
		rot_y = cy;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x <= '0;
			y <= '0;
		end else begin
			case (op)
				CELL_CLEAR: begin
					x <= '0;
					y <= '0;
				end
				// x keeps the running R entry
				CELL_LOAD: y <= load_y;
				CELL_ROT: begin
					x <= rot_x;
					y <= rot_y;
				end
				CELL_SCALE: begin
					x <= k_scale(x);
					y <= k_scale(y);
				end
				default: ;
			endcase
		end
	end

	// Vectoring only grows x, so the R diagonal comes out non-negative
	assert property (@(posedge clk) disable iff (rst) (op == CELL_SCALE) |=> !x[DATA_W-1]);

endmodule

// File: rtl/cordic_rotate_cell.sv
`timescale 1ns/10ps

module cordic_rotate_cell import qr_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  cell_op_t                     op,
	input  logic [ITER_W-1:0]            iter,
	input  logic signed [DATA_W-1:0]     load_y,
	input  logic [ITER_PER_CYCLE-1:0]    dir,
	input  logic                         neg,
	output logic signed [DATA_W-1:0]     x,
	output logic signed [DATA_W-1:0]     y
);

	logic signed [DATA_W-1:0] cx;
	logic signed [DATA_W-1:0] cy;
	logic signed [DATA_W-1:0] tx;
	logic signed [DATA_W-1:0] rot_x;
	logic signed [DATA_W-1:0] rot_y;
	logic [ITER_W-1:0]        sh;

	// Same shifts as the vectoring cell, directions taken from it
	always_comb begin
		cx = neg ? -x : x;
		cy = neg ? -y : y;
		for (int k = 0; k < ITER_PER_CYCLE; k++) begin
			sh = iter + ITER_W'(k);
			tx = cx;
			if (dir[k]) begin
				cx = cx + (cy >>> sh);
				cy = cy - (tx >>> sh);
			end else begin
				cx = cx - (cy >>> sh);
				cy = cy + (tx >>> sh);
			end
		end
		rot_x = cx;
		rot_y = cy;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x <= '0;
			y <= '0;
		end else begin
			case (op)
				CELL_CLEAR: begin
					x <= '0;
					y <= '0;
				end
				CELL_LOAD: y <= load_y;
				CELL_ROT: begin
					x <= rot_x;
					y <= rot_y;
				end
				CELL_SCALE: begin
					x <= k_scale(x);
					y <= k_scale(y);
				end
				default: ;
			endcase
		end
	end

endmodule

// File: rtl/qr_ctrl_fsm.sv
`timescale 1ns/10ps

module qr_ctrl_fsm import qr_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       en,
	input  logic                       iter_last,
	input  logic                       row_last,
	input  logic [WR_IDX_W-1:0]        wr_idx,
	input  logic signed [DATA_W-1:0]   r11,
	input  logic signed [DATA_W-1:0]   r12,
	input  logic signed [DATA_W-1:0]   r22,
	input  logic signed [DATA_W-1:0]   resid,
	output cell_op_t                   vec1_op,
	output cell_op_t                   vec2_op,
	output cell_op_t                   rot_op,
	output logic                       iter_step,
	output logic                       row_step,
	output logic                       start,
	output logic                       wr_step,
	output logic                       rd_a,
	output logic [COL_W-1:0]           rd_a_col,
	output logic                       wr_r,
	output logic [ROW_W-1:0]           wr_r_row,
	output logic [COL_W-1:0]           wr_r_col,
	output logic signed [DATA_W-1:0]   wr_r_data,
	output logic                       valid
);

	qr_state_t state;
	qr_state_t next_state;
	logic [WR_IDX_W-1:0] sel_idx;

	always_comb begin
		next_state = state;
		case (state)
			IDLE:    next_state = en ? READ0 : IDLE;
			READ0:   next_state = READ1;
			READ1:   next_state = LOAD_A;
			LOAD_A:  next_state = ROT_A;
			ROT_A:   next_state = iter_last ? SCALE_A : ROT_A;
			SCALE_A: next_state = LOAD_B;
			LOAD_B:  next_state = ROT_B;
			ROT_B:   next_state = iter_last ? SCALE_B : ROT_B;
			SCALE_B: next_state = row_last ? WRITE : READ0;
			WRITE:   next_state = (wr_idx == WR_IDX_W'(R_NUM - 1)) ? DONE : WRITE;
			DONE:    next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Controls are registered for the state being entered
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vec1_op   <= CELL_HOLD;
			vec2_op   <= CELL_HOLD;
			rot_op    <= CELL_HOLD;
			start     <= 1'b0;
			iter_step <= 1'b0;
			row_step  <= 1'b0;
			wr_step   <= 1'b0;
			rd_a      <= 1'b0;
			rd_a_col  <= '0;
			wr_r      <= 1'b0;
			valid     <= 1'b0;
		end else begin
			vec1_op <= CELL_HOLD;
			vec2_op <= CELL_HOLD;
			rot_op  <= CELL_HOLD;
			case (next_state)
				READ0: begin
					// Fresh run wipes all three accumulators
					if (state == IDLE) begin
						vec1_op <= CELL_CLEAR;
						vec2_op <= CELL_CLEAR;
						rot_op  <= CELL_CLEAR;
					end
				end
				READ1:   vec1_op <= CELL_LOAD;
				LOAD_A:  rot_op <= CELL_LOAD;
				ROT_A: begin
					vec1_op <= CELL_ROT;
					rot_op  <= CELL_ROT;
				end
				SCALE_A: begin
					vec1_op <= CELL_SCALE;
					rot_op  <= CELL_SCALE;
				end
				LOAD_B:  vec2_op <= CELL_LOAD;
				ROT_B:   vec2_op <= CELL_ROT;
				SCALE_B: vec2_op <= CELL_SCALE;
				default: ;
			endcase
			start     <= (state == IDLE) && en;
			iter_step <= (next_state == ROT_A) || (next_state == ROT_B);
			row_step  <= next_state == SCALE_B;
			wr_step   <= next_state == WRITE;
			rd_a      <= (next_state == READ0) || (next_state == READ1);
			rd_a_col  <= (next_state == READ1) ? COL_W'(COL_NUM - 1) : '0;
			wr_r      <= next_state == WRITE;
			valid     <= next_state == DONE;
		end
	end

	// Next entry to present, as wr_idx counts the writes already out
	assign sel_idx = (state == WRITE) ? wr_idx + 1'b1 : '0;

	always_ff @(posedge clk) begin
		if (next_state == WRITE) begin
			case (sel_idx)
				0: begin
					wr_r_row  <= '0;
					wr_r_col  <= '0;
					wr_r_data <= r11;
				end
				1: begin
					wr_r_row  <= '0;
					wr_r_col  <= COL_W'(1);
					wr_r_data <= r12;
				end
				default: begin
					wr_r_row  <= ROW_W'(1);
					wr_r_col  <= COL_W'(1);
					wr_r_data <= r22;
				end
			endcase
		end
	end

	// Each write sits in WRITE at the address its write index names
	assert property (@(posedge clk) disable iff (rst)
		wr_r |-> (state == WRITE)
			&& (wr_r_row == ROW_W'(wr_idx == WR_IDX_W'(R_NUM - 1)))
			&& (wr_r_col == COL_W'(wr_idx != '0)));

	// Rotate cell must sit still while cell 2 vectors its residual
	assert property (@(posedge clk) disable iff (rst) (state == ROT_B) |-> $stable(resid));

endmodule

// File: rtl/qr_cordic_top.sv
`timescale 1ns/10ps

module qr_cordic_top import qr_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       en,
	output logic                       rd_a,
	output logic [ROW_W-1:0]           rd_a_row,
	output logic [COL_W-1:0]           rd_a_col,
	input  logic signed [DATA_W-1:0]   rd_a_data,
	output logic                       wr_r,
	output logic [ROW_W-1:0]           wr_r_row,
	output logic [COL_W-1:0]           wr_r_col,
	output logic signed [DATA_W-1:0]   wr_r_data,
	output logic                       valid
);

	cell_op_t                  vec1_op;
	cell_op_t                  vec2_op;
	cell_op_t                  rot_op;
	logic                      iter_step;
	logic                      row_step;
	logic                      start;
	logic                      wr_step;
	logic [ITER_W-1:0]         iter;
	logic                      iter_last;
	logic                      row_last;
	logic [WR_IDX_W-1:0]       wr_idx;
	logic signed [DATA_W-1:0]  r11;
	logic signed [DATA_W-1:0]  r12;
	logic signed [DATA_W-1:0]  r22;
	logic signed [DATA_W-1:0]  resid;
	logic [ITER_PER_CYCLE-1:0] dir1;
	logic                      neg1;

	qr_ctrl_fsm u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.iter_last (iter_last),
		.row_last  (row_last),
		.wr_idx    (wr_idx),
		.r11       (r11),
		.r12       (r12),
		.r22       (r22),
		.resid     (resid),
		.vec1_op   (vec1_op),
		.vec2_op   (vec2_op),
		.rot_op    (rot_op),
		.iter_step (iter_step),
		.row_step  (row_step),
		.start     (start),
		.wr_step   (wr_step),
		.rd_a      (rd_a),
		.rd_a_col  (rd_a_col),
		.wr_r      (wr_r),
		.wr_r_row  (wr_r_row),
		.wr_r_col  (wr_r_col),
		.wr_r_data (wr_r_data),
		.valid     (valid)
	);

	// Row index doubles as the read row address
	qr_step_counter u_cnt (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.iter_step (iter_step),
		.row_step  (row_step),
		.wr_step   (wr_step),
		.iter      (iter),
		.iter_last (iter_last),
		.row       (rd_a_row),
		.row_last  (row_last),
		.wr_idx    (wr_idx)
	);

	// Phase A, first column
	cordic_vector_cell u_vec_r11 (
		.clk    (clk),
		.rst    (rst),
		.op     (vec1_op),
		.iter   (iter),
		.load_y (rd_a_data),
		.x      (r11),
		.y      (),
		.dir    (dir1),
		.neg    (neg1)
	);

	cordic_rotate_cell u_rot_r12 (
		.clk    (clk),
		.rst    (rst),
		.op     (rot_op),
		.iter   (iter),
		.load_y (rd_a_data),
		.dir    (dir1),
		.neg    (neg1),
		.x      (r12),
		.y      (resid)
	);

	// Phase B, nothing downstream needs its decisions
	cordic_vector_cell u_vec_r22 (
		.clk    (clk),
		.rst    (rst),
		.op     (vec2_op),
		.iter   (iter),
		.load_y (resid),
		.x      (r22),
		.y      (),
		.dir    (),
		.neg    ()
	);

endmodule

// File: tb/qr_ref_model.svh
`ifndef QR_REF_MODEL_SVH
`define QR_REF_MODEL_SVH

// Gain correction, floor of v * K / 2^K_FRAC
function automatic logic signed [DATA_W-1:0] gain_scale(input logic signed [DATA_W-1:0] v);
	int p;
	p = int'(v) * int'(K_GAIN);
	return DATA_W'(p >>> K_FRAC);
endfunction

// Twelve micro-rotations that turn (vx, vy) onto the x axis
// (rx, ry) follows the same turns
task automatic givens_phase(
	inout logic signed [DATA_W-1:0] vx,
	inout logic signed [DATA_W-1:0] vy,
	inout logic signed [DATA_W-1:0] rx,
	inout logic signed [DATA_W-1:0] ry
);
	logic signed [DATA_W-1:0] old_vx;
	logic signed [DATA_W-1:0] old_rx;
	// Left half-plane start gets a half turn first
	if (vx[DATA_W-1]) begin
		vx = -vx;
		vy = -vy;
		rx = -rx;
		ry = -ry;
	end
	for (int i = 0; i < ITER_NUM; i++) begin
		old_vx = vx;
		old_rx = rx;
		if (!vy[DATA_W-1]) begin
			vx = vx + (vy >>> i);
			vy = vy - (old_vx >>> i);
			rx = rx + (ry >>> i);
			ry = ry - (old_rx >>> i);
		end else begin
			vx = vx - (vy >>> i);
			vy = vy + (old_vx >>> i);
			rx = rx - (ry >>> i);
			ry = ry + (old_rx >>> i);
		end
	end
endtask

// R of a 4x2 matrix, rows taken bottom up, a[row*COL_NUM + col]
task automatic compute_r(
	input  logic signed [DATA_W-1:0] a [ROW_NUM*COL_NUM],
	output logic signed [DATA_W-1:0] r11,
	output logic signed [DATA_W-1:0] r12,
	output logic signed [DATA_W-1:0] r22
);
	logic signed [DATA_W-1:0] x1;
	logic signed [DATA_W-1:0] y1;
	logic signed [DATA_W-1:0] x2;
	logic signed [DATA_W-1:0] y2;
	logic signed [DATA_W-1:0] x3;
	logic signed [DATA_W-1:0] y3;
	logic signed [DATA_W-1:0] dx;
	logic signed [DATA_W-1:0] dy;
	x1 = '0;
	x2 = '0;
	x3 = '0;
	for (int row = ROW_NUM - 1; row >= 0; row--) begin
		y1 = a[row * COL_NUM];
		y2 = a[row * COL_NUM + 1];
		givens_phase(x1, y1, x2, y2);
		x1 = gain_scale(x1);
		x2 = gain_scale(x2);
		y2 = gain_scale(y2);
		// Residual of column 1 feeds the second diagonal entry
		y3 = y2;
		dx = '0;
		dy = '0;
		givens_phase(x3, y3, dx, dy);
		x3 = gain_scale(x3);
	end
	r11 = x1;
	r12 = x2;
	r22 = x3;
endtask

`endif

// File: tb/tb_qr_top.sv
`timescale 1ns/10ps

module tb_qr_top import qr_pkg::*; ();

	logic                     clk;
	logic                     rst;
	logic                     en;
	logic                     rd_a;
	logic [ROW_W-1:0]         rd_a_row;
	logic [COL_W-1:0]         rd_a_col;
	logic signed [DATA_W-1:0] rd_a_data;
	logic                     wr_r;
	logic [ROW_W-1:0]         wr_r_row;
	logic [COL_W-1:0]         wr_r_col;
	logic signed [DATA_W-1:0] wr_r_data;
	logic                     valid;

	logic signed [DATA_W-1:0] mat [ROW_NUM*COL_NUM];
	logic [DATA_W-1:0]        exp_r [R_NUM];
	int seed;
	int cyc;
	int value_errs;
	int other_errs;
	bit hung;

	// Strobes seen per run, with the cycle of each
	int en_cyc[$];
	int rd_cyc[$];
	int rd_row[$];
	int rd_col[$];
	int wr_cyc[$];
	int wr_row[$];
	int wr_col[$];
	logic [DATA_W-1:0] wr_dat[$];
	int val_cyc[$];

`include "qr_ref_model.svh"

	qr_cordic_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.rd_a      (rd_a),
		.rd_a_row  (rd_a_row),
		.rd_a_col  (rd_a_col),
		.rd_a_data (rd_a_data),
		.wr_r      (wr_r),
		.wr_r_row  (wr_r_row),
		.wr_r_col  (wr_r_col),
		.wr_r_data (wr_r_data),
		.valid     (valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// Matrix memory, data one cycle after the strobe
	always @(posedge clk) begin
		if (rd_a) begin
			rd_a_data <= mat[int'(rd_a_row) * COL_NUM + int'(rd_a_col)];
		end
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
			value_errs++;
		end
	endtask

	task automatic check_quiet();
		check_value("rd_a", 32'(rd_a), 0);
		check_value("wr_r", 32'(wr_r), 0);
		check_value("valid", 32'(valid), 0);
	endtask

	always @(negedge clk) begin
		if (rst) begin
			check_quiet();
		end else begin
			if (en) en_cyc.push_back(cyc);
			if (rd_a) begin
				rd_cyc.push_back(cyc);
				rd_row.push_back(int'(rd_a_row));
				rd_col.push_back(int'(rd_a_col));
			end
			if (wr_r) begin
				wr_cyc.push_back(cyc);
				wr_row.push_back(int'(wr_r_row));
				wr_col.push_back(int'(wr_r_col));
				wr_dat.push_back(wr_r_data);
			end
			if (valid) val_cyc.push_back(cyc);
		end
	end

	task automatic clear_logs();
		en_cyc.delete();
		rd_cyc.delete();
		rd_row.delete();
		rd_col.delete();
		wr_cyc.delete();
		wr_row.delete();
		wr_col.delete();
		wr_dat.delete();
		val_cyc.delete();
	endtask

	// New matrix with entries within +-0.5, and its expected R
	task automatic fill_matrix(input bit zero_col0, input bit neg_col0);
		int r;
		logic signed [DATA_W-1:0] r11;
		logic signed [DATA_W-1:0] r12;
		logic signed [DATA_W-1:0] r22;
		for (int i = 0; i < ROW_NUM * COL_NUM; i++) begin
			r = $random(seed) % 513;
			if (i % COL_NUM == 0 && zero_col0) begin
				r = 0;
			end else if (i % COL_NUM == 0 && neg_col0) begin
				r = (r > 0) ? -r : ((r == 0) ? -1 : r);
			end
			mat[i] = DATA_W'(r);
		end
		compute_r(mat, r11, r12, r22);
		exp_r[0] = r11;
		exp_r[1] = r12;
		exp_r[2] = r22;
	endtask

	task automatic wait_valid();
		int t;
		t = 0;
		while (val_cyc.size() == 0 && t < 100) begin
			@(posedge clk);
			t++;
		end
		if (val_cyc.size() == 0) begin
			$display("Timeout: valid did not pulse within %0d cycles", t);
			other_errs++;
			hung = 1'b1;
		end else begin
			// One more cycle to catch a second pulse
			@(posedge clk);
		end
	endtask

	// Cycles counted from the first rd_a of the run
	task automatic check_schedule(input bit check_start);
		int base;
		assert (rd_cyc.size() == 2 * ROW_NUM) else begin
			$display("Expected %0d reads in the run, saw %0d", 2 * ROW_NUM, rd_cyc.size());
			other_errs++;
		end
		assert (wr_cyc.size() == R_NUM) else begin
			$display("Expected %0d writes in the run, saw %0d", R_NUM, wr_cyc.size());
			other_errs++;
		end
		assert (val_cyc.size() == 1) else begin
			$display("Expected one valid pulse, saw %0d", val_cyc.size());
			other_errs++;
		end
		base = (rd_cyc.size() > 0) ? rd_cyc[0] : 0;
		if (check_start && en_cyc.size() > 0 && rd_cyc.size() > 0) begin
			check_value("rd_a delay after en", rd_cyc[0] - en_cyc[0], 1);
		end
		for (int i = 0; i < rd_cyc.size() && i < 2 * ROW_NUM; i++) begin
			check_value("rd_a cycle", rd_cyc[i] - base, 12 * (i / 2) + i % 2);
			check_value("rd_a_row", rd_row[i], ROW_NUM - 1 - i / 2);
			check_value("rd_a_col", rd_col[i], i % 2);
		end
		// r11 at (0,0), r12 at (0,1), r22 at (1,1)
		for (int j = 0; j < wr_cyc.size() && j < R_NUM; j++) begin
			check_value("wr_r cycle", wr_cyc[j] - base, 48 + j);
			check_value("wr_r_row", wr_row[j], j / 2);
			check_value("wr_r_col", wr_col[j], (j > 0) ? 1 : 0);
			check_value("wr_r_data", 32'(wr_dat[j]), 32'(exp_r[j]));
		end
		if (val_cyc.size() > 0) begin
			check_value("valid cycle", val_cyc[0] - base, 51);
		end
	endtask

	task automatic run_single();
		if (hung) return;
		@(posedge clk);
		clear_logs();
		en <= 1'b1;
		@(posedge clk);
		en <= 1'b0;
		wait_valid();
		if (!hung) check_schedule(1'b1);
	endtask

	// en stays high, the second run restarts straight from IDLE
	task automatic run_back_to_back();
		if (hung) return;
		fill_matrix(1'b0, 1'b0);
		@(posedge clk);
		clear_logs();
		en <= 1'b1;
		wait_valid();
		if (hung) return;
		check_schedule(1'b1);
		clear_logs();
		fill_matrix(1'b0, 1'b0);
		en <= 1'b0;
		wait_valid();
		if (!hung) check_schedule(1'b0);
	endtask

	initial begin
		seed = 32'h5629;
		cyc = 0;
		value_errs = 0;
		other_errs = 0;
		hung = 1'b0;
		rst = 1'b1;
		en = 1'b0;
		rd_a_data = '0;
		fill_matrix(1'b0, 1'b0);
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_quiet();
		end
		for (int n = 0; n < 20; n++) begin
			fill_matrix(1'b0, 1'b0);
			run_single();
		end
		// Zero first column, then a negative first column
		fill_matrix(1'b1, 1'b0);
		run_single();
		fill_matrix(1'b0, 1'b1);
		run_single();
		run_back_to_back();
		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+tb
rtl/qr_pkg.sv
rtl/qr_step_counter.sv
rtl/cordic_vector_cell.sv
rtl/cordic_rotate_cell.sv
rtl/qr_ctrl_fsm.sv
rtl/qr_cordic_top.sv
tb/tb_qr_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CORDIC QR testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_qr_top \
	-f flist.f \
	-o sim_qr

./obj_dir/sim_qr | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
	exit 0
else
	exit 1
fi
